// ==== logic/axi_params.svh ====
`ifndef AXI_PARAMS_SVH
`define AXI_PARAMS_SVH

// bus widths shared by the whole memory subsystem
`define AXI_ADDR_W 64
`define AXI_DATA_W 64
`define AXI_ID_W   4

// master IDs seen on the shared port
`define AXI_IF_ID  0           // instruction fetch
`define AXI_LS_ID  1           // load/store unit

`endif

// ==== logic/axi_pkg.sv ====
`include "axi_params.svh"

package axi_pkg;

    // one bus address
    typedef logic [`AXI_ADDR_W-1:0] addr_t;

    // one data beat
    typedef logic [`AXI_DATA_W-1:0] data_t;

    typedef logic [`AXI_DATA_W/8-1:0] strb_t;      // one enable per byte lane

    typedef logic [`AXI_ID_W-1:0] id_t;            // transaction id

    typedef logic [2:0] size_t;                    // log2 of bytes per beat

endpackage

// ==== logic/axi_lite_if.sv ====
`timescale 1ns/1ps
`include "axi_params.svh"

interface axi_lite_if;

    logic            ar_valid;
    logic            ar_ready;
    axi_pkg::addr_t  ar_addr;
    axi_pkg::id_t    ar_id;
    axi_pkg::size_t  ar_size;

    logic            r_valid;
    logic            r_ready;
    axi_pkg::data_t  r_data;
    axi_pkg::id_t    r_id;

    logic            aw_valid;
    logic            aw_ready;
    axi_pkg::addr_t  aw_addr;
    axi_pkg::id_t    aw_id;
    axi_pkg::size_t  aw_size;

    logic            w_valid;
    logic            w_ready;
    axi_pkg::data_t  w_data;
    axi_pkg::strb_t  w_strb;

    logic            b_valid;
    logic            b_ready;
    axi_pkg::id_t    b_id;

    modport master (
        output ar_valid, ar_addr, ar_id, ar_size, r_ready,
        output aw_valid, aw_addr, aw_id, aw_size,
        output w_valid, w_data, w_strb, b_ready,
        input  ar_ready, r_valid, r_data, r_id,
        input  aw_ready, w_ready, b_valid, b_id
    );

    modport slave (
        input  ar_valid, ar_addr, ar_id, ar_size, r_ready,
        input  aw_valid, aw_addr, aw_id, aw_size,
        input  w_valid, w_data, w_strb, b_ready,
        output ar_ready, r_valid, r_data, r_id,
        output aw_ready, w_ready, b_valid, b_id
    );

endinterface

// ==== logic/fetch_axi_bridge.sv ====
`timescale 1ns/1ps
`include "axi_params.svh"

module fetch_axi_bridge (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            rw_valid_i,
    input  axi_pkg::addr_t  rw_addr_i,
    output logic            rw_ready_o,
    output axi_pkg::data_t  data_read_o,
    axi_lite_if.master      axi
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } state_t;

    state_t          state_q;
    axi_pkg::addr_t  addr_q;
    logic            start;
    logic            ar_fire;
    logic            r_fire;

    assign start   = rw_valid_i && !rw_ready_o;        // ignore request during done pulse
    assign ar_fire = axi.ar_valid && axi.ar_ready;
    assign r_fire  = axi.r_valid && axi.r_ready;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_IDLE;
            rw_ready_o <= 1'b0;
        end else begin
            rw_ready_o <= r_fire;                      // done one cycle after R
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (ar_fire) begin
                        state_q <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (r_fire) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && start) begin
            addr_q <= rw_addr_i;                       // hold address for AR
        end
        if (r_fire) begin
            data_read_o <= axi.r_data;
        end
    end

    assign axi.ar_valid = (state_q == ST_ADDR);
    assign axi.ar_addr  = addr_q;
    assign axi.ar_id    = axi_pkg::id_t'(`AXI_IF_ID);
    assign axi.ar_size  = axi_pkg::size_t'($clog2(`AXI_DATA_W / 8));   // always full width
    assign axi.r_ready  = (state_q == ST_DATA);

    // address request must not be withdrawn or changed before the slave takes it
    ar_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        axi.ar_valid && !axi.ar_ready |=> axi.ar_valid && $stable(axi.ar_addr));

endmodule

// ==== logic/lsu_axi_bridge.sv ====
`timescale 1ns/1ps
`include "axi_params.svh"

module lsu_axi_bridge (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            rd_en_i,
    input  logic            wr_en_i,
    input  axi_pkg::addr_t  addr_i,
    input  axi_pkg::data_t  wr_data_i,
    input  axi_pkg::strb_t  wr_mask_i,
    input  axi_pkg::size_t  wr_size_i,
    output logic            rd_done_o,
    output axi_pkg::data_t  rd_data_o,
    output logic            wr_ok_o,
    axi_lite_if.master      axi
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_AR,
        ST_R,
        ST_WR,
        ST_B
    } state_t;

    state_t          state_q;
    logic            aw_sent_q;
    logic            w_sent_q;
    axi_pkg::addr_t  addr_q;
    axi_pkg::data_t  wdata_q;
    axi_pkg::strb_t  mask_q;
    axi_pkg::size_t  size_q;
    logic            busy_done;
    logic            start;
    logic            ar_fire;
    logic            r_fire;
    logic            aw_fire;
    logic            w_fire;
    logic            b_fire;

    assign busy_done = rd_done_o || wr_ok_o;           // pulse cycle, no new start
    assign start     = (rd_en_i || wr_en_i) && !busy_done;
    assign ar_fire   = axi.ar_valid && axi.ar_ready;
    assign r_fire    = axi.r_valid && axi.r_ready;
    assign aw_fire   = axi.aw_valid && axi.aw_ready;
    assign w_fire    = axi.w_valid && axi.w_ready;
    assign b_fire    = axi.b_valid && axi.b_ready;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ST_IDLE;
            aw_sent_q <= 1'b0;
            w_sent_q  <= 1'b0;
            rd_done_o <= 1'b0;
            wr_ok_o   <= 1'b0;
        end else begin
            rd_done_o <= r_fire;
            wr_ok_o   <= b_fire;
            case (state_q)
                ST_IDLE: begin
                    aw_sent_q <= 1'b0;
                    w_sent_q  <= 1'b0;
                    if (start) begin
                        state_q <= wr_en_i ? ST_WR : ST_AR;   // write wins
                    end
                end
                ST_AR: begin
                    if (ar_fire) begin
                        state_q <= ST_R;
                    end
                end
                ST_R: begin
                    if (r_fire) begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_WR: begin
                    if (aw_fire) begin
                        aw_sent_q <= 1'b1;
                    end
                    if (w_fire) begin
                        w_sent_q <= 1'b1;
                    end
                    if ((aw_sent_q || aw_fire) && (w_sent_q || w_fire)) begin
                        state_q <= ST_B;               // both halves accepted
                    end
                end
                ST_B: begin
                    if (b_fire) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && start) begin
            addr_q  <= addr_i;
            wdata_q <= wr_data_i;
            mask_q  <= wr_mask_i;
            size_q  <= wr_size_i;
        end
        if (r_fire) begin
            rd_data_o <= axi.r_data;
        end
    end

    assign axi.ar_valid = (state_q == ST_AR);
    assign axi.ar_addr  = addr_q;
    assign axi.ar_id    = axi_pkg::id_t'(`AXI_LS_ID);
    assign axi.ar_size  = axi_pkg::size_t'($clog2(`AXI_DATA_W / 8));
    assign axi.r_ready  = (state_q == ST_R);

    assign axi.aw_valid = (state_q == ST_WR) && !aw_sent_q;
    assign axi.aw_addr  = addr_q;
    assign axi.aw_id    = axi_pkg::id_t'(`AXI_LS_ID);
    assign axi.aw_size  = size_q;
    assign axi.w_valid  = (state_q == ST_WR) && !w_sent_q;
    assign axi.w_data   = wdata_q;
    assign axi.w_strb   = mask_q;
    assign axi.b_ready  = (state_q == ST_B);

    aw_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        axi.aw_valid && !axi.aw_ready |=>
            axi.aw_valid && $stable(axi.aw_addr) && $stable(axi.aw_size));

    w_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        axi.w_valid && !axi.w_ready |=>
            axi.w_valid && $stable(axi.w_data) && $stable(axi.w_strb));

    // one transaction in flight, so completions never overlap
    done_excl_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(rd_done_o && wr_ok_o));

endmodule

// ==== logic/axi_crossbar.sv ====
`timescale 1ns/1ps
`include "axi_params.svh"

module axi_crossbar (
    input  logic        clk,
    input  logic        arst_n_i,
    axi_lite_if.slave   if_bus,
    axi_lite_if.slave   ls_bus,
    axi_lite_if.master  mem_bus
);

    localparam axi_pkg::id_t IF_ID = axi_pkg::id_t'(`AXI_IF_ID);
    localparam axi_pkg::id_t LS_ID = axi_pkg::id_t'(`AXI_LS_ID);

    logic          rd_busy_q;      // one read outstanding
    logic          grant_ls_q;     // granted master, 1 = load/store
    logic          ar_pend_q;      // AR shown but not yet taken
    logic          sel_ls;
    logic          ar_fire;
    logic          r_is_if;
    logic          r_is_ls;
    logic          r_fire_gnt;
    axi_pkg::id_t  gnt_id;

    // keep the choice fixed while an AR waits, so the payload stays stable
    assign sel_ls = ar_pend_q ? grant_ls_q : ls_bus.ar_valid;
    assign gnt_id = grant_ls_q ? LS_ID : IF_ID;

    assign mem_bus.ar_valid = !rd_busy_q && (if_bus.ar_valid || ls_bus.ar_valid);
    assign mem_bus.ar_addr  = sel_ls ? ls_bus.ar_addr : if_bus.ar_addr;
    assign mem_bus.ar_size  = sel_ls ? ls_bus.ar_size : if_bus.ar_size;
    assign mem_bus.ar_id    = sel_ls ? LS_ID : IF_ID;      // master id replaces requester id
    assign ls_bus.ar_ready  = !rd_busy_q && sel_ls && mem_bus.ar_ready;
    assign if_bus.ar_ready  = !rd_busy_q && !sel_ls && mem_bus.ar_ready;

    assign ar_fire = mem_bus.ar_valid && mem_bus.ar_ready;

    // R goes back by id
    assign r_is_if = rd_busy_q && (mem_bus.r_id == IF_ID);
    assign r_is_ls = rd_busy_q && (mem_bus.r_id == LS_ID);

    assign if_bus.r_valid = mem_bus.r_valid && r_is_if;
    assign if_bus.r_data  = mem_bus.r_data;
    assign if_bus.r_id    = mem_bus.r_id;
    assign ls_bus.r_valid = mem_bus.r_valid && r_is_ls;
    assign ls_bus.r_data  = mem_bus.r_data;
    assign ls_bus.r_id    = mem_bus.r_id;
    assign mem_bus.r_ready = (r_is_if && if_bus.r_ready) || (r_is_ls && ls_bus.r_ready);

    assign r_fire_gnt = mem_bus.r_valid && mem_bus.r_ready && (mem_bus.r_id == gnt_id);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_busy_q  <= 1'b0;
            grant_ls_q <= 1'b0;
            ar_pend_q  <= 1'b0;
        end else if (!rd_busy_q) begin
            if (ar_fire) begin
                rd_busy_q  <= 1'b1;
                grant_ls_q <= sel_ls;
                ar_pend_q  <= 1'b0;
            end else if (mem_bus.ar_valid) begin
                grant_ls_q <= sel_ls;                  // lock until accepted
                ar_pend_q  <= 1'b1;
            end
        end else if (r_fire_gnt) begin
            rd_busy_q <= 1'b0;                         // grant released
        end
    end

    // writes belong to the load/store master only
    assign mem_bus.aw_valid = ls_bus.aw_valid;
    assign mem_bus.aw_addr  = ls_bus.aw_addr;
    assign mem_bus.aw_id    = LS_ID;
    assign mem_bus.aw_size  = ls_bus.aw_size;
    assign ls_bus.aw_ready  = mem_bus.aw_ready;
    assign mem_bus.w_valid  = ls_bus.w_valid;
    assign mem_bus.w_data   = ls_bus.w_data;
    assign mem_bus.w_strb   = ls_bus.w_strb;
    assign ls_bus.w_ready   = mem_bus.w_ready;
    assign ls_bus.b_valid   = mem_bus.b_valid;
    assign ls_bus.b_id      = mem_bus.b_id;
    assign mem_bus.b_ready  = ls_bus.b_ready;

    // fetch side has no write path
    assign if_bus.aw_ready = 1'b0;
    assign if_bus.w_ready  = 1'b0;
    assign if_bus.b_valid  = 1'b0;
    assign if_bus.b_id     = IF_ID;

    // a response only ever answers the read this crossbar let through
    r_owner_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_bus.r_valid |-> rd_busy_q && (mem_bus.r_id == gnt_id));

endmodule

// ==== logic/mem_subsys_top.sv ====
`timescale 1ns/1ps
`include "axi_params.svh"

module mem_subsys_top (
    input  logic            clk,
    input  logic            arst_n_i,

    input  logic            if_rw_valid_i,
    input  axi_pkg::addr_t  if_rw_addr_i,
    output logic            if_rw_ready_o,
    output axi_pkg::data_t  if_data_read_o,

    input  logic            ls_rd_en_i,
    input  logic            ls_wr_en_i,
    input  axi_pkg::addr_t  ls_addr_i,
    input  axi_pkg::data_t  ls_wr_data_i,
    input  axi_pkg::strb_t  ls_wr_mask_i,
    input  axi_pkg::size_t  ls_wr_size_i,
    output logic            ls_rd_done_o,
    output axi_pkg::data_t  ls_rd_data_o,
    output logic            ls_wr_ok_o,

    input  logic            axi_ar_ready_i,
    output logic            axi_ar_valid_o,
    output axi_pkg::addr_t  axi_ar_addr_o,
    output axi_pkg::id_t    axi_ar_id_o,
    output axi_pkg::size_t  axi_ar_size_o,

    output logic            axi_r_ready_o,
    input  logic            axi_r_valid_i,
    input  axi_pkg::data_t  axi_r_data_i,
    input  axi_pkg::id_t    axi_r_id_i,

    input  logic            axi_aw_ready_i,
    output logic            axi_aw_valid_o,
    output axi_pkg::addr_t  axi_aw_addr_o,
    output axi_pkg::id_t    axi_aw_id_o,
    output axi_pkg::size_t  axi_aw_size_o,

    input  logic            axi_w_ready_i,
    output logic            axi_w_valid_o,
    output axi_pkg::data_t  axi_w_data_o,
    output axi_pkg::strb_t  axi_w_strb_o,

    output logic            axi_b_ready_o,
    input  logic            axi_b_valid_i,
    input  axi_pkg::id_t    axi_b_id_i
);

    axi_lite_if if_bus ();     // fetch, master id 0
    axi_lite_if ls_bus ();     // load/store, master id 1
    axi_lite_if mem_bus ();    // shared downstream port

    fetch_axi_bridge u_fetch_bridge (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .rw_valid_i  (if_rw_valid_i),
        .rw_addr_i   (if_rw_addr_i),
        .rw_ready_o  (if_rw_ready_o),
        .data_read_o (if_data_read_o),
        .axi         (if_bus.master)
    );

    lsu_axi_bridge u_lsu_bridge (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rd_en_i   (ls_rd_en_i),
        .wr_en_i   (ls_wr_en_i),
        .addr_i    (ls_addr_i),
        .wr_data_i (ls_wr_data_i),
        .wr_mask_i (ls_wr_mask_i),
        .wr_size_i (ls_wr_size_i),
        .rd_done_o (ls_rd_done_o),
        .rd_data_o (ls_rd_data_o),
        .wr_ok_o   (ls_wr_ok_o),
        .axi       (ls_bus.master)
    );

    axi_crossbar u_crossbar (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .if_bus   (if_bus.slave),
        .ls_bus   (ls_bus.slave),
        .mem_bus  (mem_bus.master)
    );

    assign axi_ar_valid_o   = mem_bus.ar_valid;
    assign axi_ar_addr_o    = mem_bus.ar_addr;
    assign axi_ar_id_o      = mem_bus.ar_id;
    assign axi_ar_size_o    = mem_bus.ar_size;
    assign mem_bus.ar_ready = axi_ar_ready_i;

    assign axi_r_ready_o    = mem_bus.r_ready;
    assign mem_bus.r_valid  = axi_r_valid_i;
    assign mem_bus.r_data   = axi_r_data_i;
    assign mem_bus.r_id     = axi_r_id_i;

    assign axi_aw_valid_o   = mem_bus.aw_valid;
    assign axi_aw_addr_o    = mem_bus.aw_addr;
    assign axi_aw_id_o      = mem_bus.aw_id;
    assign axi_aw_size_o    = mem_bus.aw_size;
    assign mem_bus.aw_ready = axi_aw_ready_i;

    assign axi_w_valid_o    = mem_bus.w_valid;
    assign axi_w_data_o     = mem_bus.w_data;
    assign axi_w_strb_o     = mem_bus.w_strb;
    assign mem_bus.w_ready  = axi_w_ready_i;

    assign axi_b_ready_o    = mem_bus.b_ready;
    assign mem_bus.b_valid  = axi_b_valid_i;
    assign mem_bus.b_id     = axi_b_id_i;

endmodule

// ==== verif/axi_mem_model.sv ====
`timescale 1ns/1ps
`include "axi_params.svh"

module axi_mem_model #(
    parameter axi_pkg::data_t FILL_KEY = '0
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            ar_valid_i,
    output logic            ar_ready_o,
    input  axi_pkg::addr_t  ar_addr_i,
    input  axi_pkg::id_t    ar_id_i,
    input  logic            r_ready_i,
    output logic            r_valid_o,
    output axi_pkg::data_t  r_data_o,
    output axi_pkg::id_t    r_id_o,
    input  logic            aw_valid_i,
    output logic            aw_ready_o,
    input  axi_pkg::addr_t  aw_addr_i,
    input  axi_pkg::id_t    aw_id_i,
    input  logic            w_valid_i,
    output logic            w_ready_o,
    input  axi_pkg::data_t  w_data_i,
    input  axi_pkg::strb_t  w_strb_i,
    input  logic            b_ready_i,
    output logic            b_valid_o,
    output axi_pkg::id_t    b_id_o
);

    localparam int OFS = $clog2(`AXI_DATA_W / 8);

    axi_pkg::data_t mem [axi_pkg::addr_t];     // sparse, keyed by word index

    function automatic axi_pkg::data_t read_word(input axi_pkg::addr_t addr);
        if (mem.exists(addr >> OFS)) begin
            return mem[addr >> OFS];
        end
        return ((addr >> OFS) << OFS) ^ FILL_KEY;  // unwritten word
    endfunction

    // read side, one transaction at a time
    initial begin
        axi_pkg::addr_t raddr;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        r_id_o     = '0;
        wait (arst_n_i);
        forever begin
            @(posedge clk);
            while (!ar_valid_i) @(posedge clk);
            repeat ($urandom_range(3, 0)) @(posedge clk);
            ar_ready_o <= 1'b1;
            @(posedge clk);                        // valid held, so this edge transfers
            ar_ready_o <= 1'b0;
            raddr = ar_addr_i;
            r_id_o <= ar_id_i;
            repeat ($urandom_range(3, 0)) @(posedge clk);
            r_valid_o <= 1'b1;
            r_data_o  <= read_word(raddr);
            @(posedge clk);
            while (!r_ready_i) @(posedge clk);
            r_valid_o <= 1'b0;
        end
    end

    // write side, AW and W accepted independently
    initial begin
        axi_pkg::addr_t waddr;
        axi_pkg::data_t wdata;
        axi_pkg::strb_t wstrb;
        axi_pkg::data_t word;
        int unsigned    aw_wait;
        int unsigned    w_wait;
        bit             aw_got;
        bit             w_got;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        b_valid_o  = 1'b0;
        b_id_o     = '0;
        wait (arst_n_i);
        forever begin
            aw_wait = $urandom_range(3, 0);
            w_wait  = $urandom_range(3, 0);
            aw_got  = 1'b0;
            w_got   = 1'b0;
            while (!(aw_got && w_got)) begin
                @(posedge clk);
                if (!aw_got && aw_ready_o && aw_valid_i) begin
                    aw_got = 1'b1;
                    aw_ready_o <= 1'b0;
                    waddr = aw_addr_i;
                    b_id_o <= aw_id_i;
                end else if (!aw_got && aw_valid_i) begin
                    if (aw_wait == 0) aw_ready_o <= 1'b1;
                    else aw_wait--;
                end
                if (!w_got && w_ready_o && w_valid_i) begin
                    w_got = 1'b1;
                    w_ready_o <= 1'b0;
                    wdata = w_data_i;
                    wstrb = w_strb_i;
                end else if (!w_got && w_valid_i) begin
                    if (w_wait == 0) w_ready_o <= 1'b1;
                    else w_wait--;
                end
            end
            word = read_word(waddr);
            for (int b = 0; b < `AXI_DATA_W / 8; b++) begin
                if (wstrb[b]) word[b*8 +: 8] = wdata[b*8 +: 8];   // byte merge
            end
            mem[waddr >> OFS] = word;
            repeat ($urandom_range(3, 0)) @(posedge clk);
            b_valid_o <= 1'b1;
            @(posedge clk);
            while (!b_ready_i) @(posedge clk);
            b_valid_o <= 1'b0;
        end
    end

endmodule

// ==== verif/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`include "axi_params.svh"

module tb_mem_subsys;

    localparam int             NUM_TESTS = 5;
    localparam axi_pkg::data_t FILL_KEY  = 64'h9e37_79b9_7f4a_7c15;
    localparam axi_pkg::id_t   IF_ID     = axi_pkg::id_t'(`AXI_IF_ID);
    localparam axi_pkg::id_t   LS_ID     = axi_pkg::id_t'(`AXI_LS_ID);

    logic            clk = 1'b0;
    logic            arst_n_i;
    logic            if_rw_valid_i;
    axi_pkg::addr_t  if_rw_addr_i;
    logic            if_rw_ready_o;
    axi_pkg::data_t  if_data_read_o;
    logic            ls_rd_en_i;
    logic            ls_wr_en_i;
    axi_pkg::addr_t  ls_addr_i;
    axi_pkg::data_t  ls_wr_data_i;
    axi_pkg::strb_t  ls_wr_mask_i;
    axi_pkg::size_t  ls_wr_size_i;
    logic            ls_rd_done_o;
    axi_pkg::data_t  ls_rd_data_o;
    logic            ls_wr_ok_o;
    logic            axi_ar_ready_i;
    logic            axi_ar_valid_o;
    axi_pkg::addr_t  axi_ar_addr_o;
    axi_pkg::id_t    axi_ar_id_o;
    axi_pkg::size_t  axi_ar_size_o;
    logic            axi_r_ready_o;
    logic            axi_r_valid_i;
    axi_pkg::data_t  axi_r_data_i;
    axi_pkg::id_t    axi_r_id_i;
    logic            axi_aw_ready_i;
    logic            axi_aw_valid_o;
    axi_pkg::addr_t  axi_aw_addr_o;
    axi_pkg::id_t    axi_aw_id_o;
    axi_pkg::size_t  axi_aw_size_o;
    logic            axi_w_ready_i;
    logic            axi_w_valid_o;
    axi_pkg::data_t  axi_w_data_o;
    axi_pkg::strb_t  axi_w_strb_o;
    logic            axi_b_ready_o;
    logic            axi_b_valid_i;
    axi_pkg::id_t    axi_b_id_i;

    int              errors   = 0;
    int              err_mark = 0;
    int              n_pass   = 0;
    int              n_fail   = 0;
    int              rd_out;                       // reads in flight on the shared port
    logic            quiet;                        // high until the first request
    axi_pkg::id_t    ar_ids [$];                   // id of every AR transfer
    axi_pkg::data_t  shadow [axi_pkg::addr_t];     // expected memory contents

    always #20 clk = ~clk;

    mem_subsys_top DUT (.*);

    axi_mem_model #(.FILL_KEY(FILL_KEY)) u_mem (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .ar_valid_i (axi_ar_valid_o),
        .ar_ready_o (axi_ar_ready_i),
        .ar_addr_i  (axi_ar_addr_o),
        .ar_id_i    (axi_ar_id_o),
        .r_ready_i  (axi_r_ready_o),
        .r_valid_o  (axi_r_valid_i),
        .r_data_o   (axi_r_data_i),
        .r_id_o     (axi_r_id_i),
        .aw_valid_i (axi_aw_valid_o),
        .aw_ready_o (axi_aw_ready_i),
        .aw_addr_i  (axi_aw_addr_o),
        .aw_id_i    (axi_aw_id_o),
        .w_valid_i  (axi_w_valid_o),
        .w_ready_o  (axi_w_ready_i),
        .w_data_i   (axi_w_data_o),
        .w_strb_i   (axi_w_strb_o),
        .b_ready_i  (axi_b_ready_o),
        .b_valid_o  (axi_b_valid_i),
        .b_id_o     (axi_b_id_i)
    );

    task automatic flag_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        errors++;
    endtask

    // unwritten words read back as their aligned address xor the key
    function automatic axi_pkg::data_t mem_word(input axi_pkg::addr_t addr);
        if (shadow.exists(addr >> 3)) begin
            return shadow[addr >> 3];
        end
        return {addr[`AXI_ADDR_W-1:3], 3'b000} ^ FILL_KEY;
    endfunction

    function automatic axi_pkg::data_t merge_bytes(input axi_pkg::data_t old_word,
                                                   input axi_pkg::data_t new_word,
                                                   input axi_pkg::strb_t mask);
        axi_pkg::data_t res;
        res = old_word;
        for (int b = 0; b < `AXI_DATA_W / 8; b++) begin
            if (mask[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic axi_pkg::addr_t rand_addr();
        axi_pkg::addr_t a;
        a = {$urandom, $urandom};
        a[2:0] = 3'b000;
        return a;
    endfunction

    // raise both requesters, load/store up to a few edges late, wait for each done pulse
    task automatic run_pair(input bit do_fetch, input axi_pkg::addr_t f_addr, input int ls_op,
                            input int ls_lag, input axi_pkg::addr_t l_addr,
                            input axi_pkg::data_t wdata, input axi_pkg::strb_t mask,
                            input axi_pkg::size_t size);
        axi_pkg::data_t f_exp;
        axi_pkg::data_t l_exp;
        bit             f_wait;
        bit             l_wait;
        int             lag;
        f_exp  = mem_word(f_addr);
        l_exp  = mem_word(l_addr);
        f_wait = do_fetch;
        l_wait = (ls_op != 0);
        lag    = ls_lag;
        @(posedge clk);
        quiet         <= 1'b0;
        if_rw_valid_i <= do_fetch;
        if_rw_addr_i  <= f_addr;
        ls_rd_en_i    <= (ls_op == 1) && (lag == 0);
        ls_wr_en_i    <= (ls_op == 2) && (lag == 0);
        ls_addr_i     <= l_addr;
        ls_wr_data_i  <= wdata;
        ls_wr_mask_i  <= mask;
        ls_wr_size_i  <= size;
        while (f_wait || l_wait) begin
            @(posedge clk);
            if (lag > 0) begin
                lag--;
                if (lag == 0) begin
                    ls_rd_en_i <= (ls_op == 1);    // load/store joins late
                    ls_wr_en_i <= (ls_op == 2);
                end
            end
            if (f_wait && if_rw_ready_o) begin
                fetch_data_a: assert (if_data_read_o == f_exp)
                    else flag_error($sformatf("fetch data %h, expected %h", if_data_read_o, f_exp));
                if_rw_valid_i <= 1'b0;
                f_wait = 1'b0;
            end
            if (l_wait && (ls_rd_done_o || ls_wr_ok_o)) begin
                if (ls_op == 1) begin
                    load_data_a: assert (ls_rd_data_o == l_exp)
                        else flag_error($sformatf("load data %h, expected %h", ls_rd_data_o, l_exp));
                end else begin
                    shadow[l_addr >> 3] = merge_bytes(l_exp, wdata, mask);
                end
                ls_rd_en_i <= 1'b0;
                ls_wr_en_i <= 1'b0;
                l_wait = 1'b0;
            end
        end
    endtask

    task automatic finish_test(input int num, input string name);
        if (errors == err_mark) begin
            n_pass++;
            $display("test %0d %s: pass", num, name);
        end else begin
            n_fail++;
            $display("test %0d %s: FAIL", num, name);
        end
        err_mark = errors;
    endtask

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_out <= 0;
        end else if (axi_ar_valid_o && axi_ar_ready_i) begin
            rd_out <= rd_out + 1;
            ar_ids.push_back(axi_ar_id_o);
        end else if (axi_r_valid_i && axi_r_ready_o) begin
            rd_out <= rd_out - 1;
        end
    end

    idle_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        quiet |-> !(axi_ar_valid_o || axi_aw_valid_o || axi_w_valid_o || axi_r_ready_o
                    || axi_b_ready_o || if_rw_ready_o || ls_rd_done_o || ls_wr_ok_o))
        else flag_error("bus or done output active before any request");
    ar_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        axi_ar_valid_o && !axi_ar_ready_i |=> axi_ar_valid_o && $stable(axi_ar_addr_o)
            && $stable(axi_ar_id_o) && $stable(axi_ar_size_o))
        else flag_error("AR valid or payload changed before its transfer");
    ar_size_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        axi_ar_valid_o && axi_ar_id_o == IF_ID |-> axi_ar_size_o == 3'd3)   // 8-byte beat
        else flag_error("fetch read does not use the full-width size code");
    aw_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        axi_aw_valid_o && !axi_aw_ready_i |=> axi_aw_valid_o && $stable(axi_aw_addr_o)
            && $stable(axi_aw_size_o))
        else flag_error("AW valid or payload changed before its transfer");
    w_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        axi_w_valid_o && !axi_w_ready_i |=> axi_w_valid_o && $stable(axi_w_data_o)
            && $stable(axi_w_strb_o))
        else flag_error("W valid or payload changed before its transfer");
    aw_payload_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        axi_aw_valid_o |-> axi_aw_size_o == ls_wr_size_i && axi_aw_addr_o == ls_addr_i
            && axi_aw_id_o == LS_ID)
        else flag_error("AW payload does not match the store request");
    w_payload_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        axi_w_valid_o |-> axi_w_data_o == ls_wr_data_i && axi_w_strb_o == ls_wr_mask_i)
        else flag_error("W payload does not match the store request");
    one_read_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        axi_ar_valid_o |-> rd_out == 0)
        else flag_error("second read issued while one was outstanding");
    if_done_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        if_rw_ready_o |-> if_rw_valid_i)
        else flag_error("fetch done pulse without a fetch request");
    if_pulse_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        if_rw_ready_o |=> !if_rw_ready_o)
        else flag_error("fetch done pulse longer than one cycle");
    rd_done_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        ls_rd_done_o |-> ls_rd_en_i)
        else flag_error("load done pulse without a load request");
    wr_ok_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        ls_wr_ok_o |-> ls_wr_en_i)
        else flag_error("store done pulse without a store request");
    ls_pulse_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        ls_rd_done_o || ls_wr_ok_o |=> !(ls_rd_done_o || ls_wr_ok_o))
        else flag_error("load/store done pulse longer than one cycle");

    // watchdog
    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("timeout: a request did not complete in %0d cycles", NUM_TESTS * 200);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        axi_pkg::addr_t a;
        int             base;
        void'($urandom(32'habb7_6a81));
        arst_n_i      = 1'b0;
        quiet         = 1'b1;
        if_rw_valid_i = 1'b0;
        if_rw_addr_i  = '0;
        ls_rd_en_i    = 1'b0;
        ls_wr_en_i    = 1'b0;
        ls_addr_i     = '0;
        ls_wr_data_i  = '0;
        ls_wr_mask_i  = '0;
        ls_wr_size_i  = '0;
        repeat (5) @(posedge clk);
        arst_n_i <= 1'b1;

        repeat ($urandom_range(6, 3)) @(posedge clk);
        finish_test(1, "idle after reset");

        run_pair(1'b1, rand_addr(), 0, 0, '0, '0, '0, '0);
        finish_test(2, "fetch read");

        a = rand_addr();
        run_pair(1'b0, '0, 2, 0, a, {$urandom, $urandom}, axi_pkg::strb_t'($urandom),
                 axi_pkg::size_t'($urandom_range(3, 0)));
        run_pair(1'b0, '0, 1, 0, a, '0, '0, '0);
        finish_test(3, "store then load");

        base = ar_ids.size();
        run_pair(1'b1, rand_addr(), 1, 0, rand_addr(), '0, '0, '0);
        first_ls_a: assert (ar_ids[base] == LS_ID)
            else flag_error($sformatf("first AR id %0d, expected %0d", ar_ids[base], LS_ID));
        finish_test(4, "contested reads");

        // fetch and load/store use separate regions so pairs never race
        for (int i = 0; i < 16; i++) begin
            run_pair($urandom_range(1, 0) == 1,
                     64'h0000_0000_1000_0000 + axi_pkg::addr_t'($urandom_range(7, 0) * 8),
                     int'($urandom_range(2, 0)),
                     int'($urandom_range(3, 0)),
                     64'h0000_0000_2000_0000 + axi_pkg::addr_t'($urandom_range(3, 0) * 8),
                     {$urandom, $urandom}, axi_pkg::strb_t'($urandom),
                     axi_pkg::size_t'($urandom_range(3, 0)));
        end
        finish_test(5, "random traffic");

        $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/axi_pkg.sv
logic/axi_lite_if.sv
logic/fetch_axi_bridge.sv
logic/lsu_axi_bridge.sv
logic/axi_crossbar.sv
logic/mem_subsys_top.sv
verif/axi_mem_model.sv
verif/tb_mem_subsys.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_mem_subsys
FILELIST  = vlog.f
OBJDIR    = obj_dir
PASS_MSG  = Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
